// ==== core.f ====
hw/core_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/immediate_generator.sv
hw/control_unit.sv
hw/core.sv
verification/core_tb.sv

// ==== verification/core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int    clock_period       = 100;
    localparam int    num_tests          = 8;
    localparam int    cycles_per_program = 200;
    localparam int    memory_words       = 64;
    localparam word_t boot_address       = 32'h0000_0000;

    logic  clk;
    logic  reset;
    logic  halt;
    logic  memory_response;
    word_t read_data;
    logic  memory_read;
    logic  memory_write;
    word_t address;
    word_t write_data;

    word_t  memory [memory_words];
    word_t  program_words [num_tests][16];
    word_t  expected_address [num_tests];
    word_t  expected_data [num_tests];
    logic   hold_halt [num_tests];
    integer seed = 32'h2edb6b12;
    int     current_test;

    core #(
        .boot_address (boot_address)
    ) dut_i (
        .clk             (clk),
        .reset           (reset),
        .halt            (halt),
        .memory_response (memory_response),
        .read_data       (read_data),
        .memory_read     (memory_read),
        .memory_write    (memory_write),
        .address         (address),
        .write_data      (write_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clock_period / 2) clk = ~clk;
    end

    // **************************************************
    // instruction encoders
    // **************************************************
    function automatic word_t encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                       input reg_index_t rd, input reg_index_t rs1,
                                       input reg_index_t rs2);
        return {funct7, rs2, rs1, funct3, rd, opcode_op};
    endfunction

    function automatic word_t encode_i(input opcode_t opcode, input logic [2:0] funct3,
                                       input reg_index_t rd, input reg_index_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    // sw rs2, imm(rs1)
    function automatic word_t encode_s(input reg_index_t rs2, input reg_index_t rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcode_store};
    endfunction

    function automatic word_t encode_b(input logic [2:0] funct3, input reg_index_t rs1,
                                       input reg_index_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], opcode_branch};
    endfunction

    function automatic word_t encode_u(input opcode_t opcode, input reg_index_t rd,
                                       input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic word_t encode_j(input reg_index_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcode_jal};
    endfunction

    function automatic word_t fill_word(input int index);
        return word_t'(32'hc0de_0000 ^ (index * 32'h0004_0004));
    endfunction

    // each branch that is not taken sets its own bit in x3
    task automatic build_branch_program(input int t, input logic [11:0] first,
                                        input logic [11:0] second, input word_t result);
        program_words[t][0]  = encode_i(opcode_op_imm, 3'b000, 1, 0, first);
        program_words[t][1]  = encode_i(opcode_op_imm, 3'b000, 2, 0, second);
        program_words[t][2]  = encode_i(opcode_op_imm, 3'b000, 3, 0, 12'd0);
        program_words[t][3]  = encode_b(3'b000, 1, 2, 13'd8);
        program_words[t][4]  = encode_i(opcode_op_imm, 3'b110, 3, 3, 12'd1);
        program_words[t][5]  = encode_b(3'b001, 1, 2, 13'd8);
        program_words[t][6]  = encode_i(opcode_op_imm, 3'b110, 3, 3, 12'd2);
        program_words[t][7]  = encode_b(3'b100, 1, 2, 13'd8);
        program_words[t][8]  = encode_i(opcode_op_imm, 3'b110, 3, 3, 12'd4);
        program_words[t][9]  = encode_b(3'b101, 1, 2, 13'd8);
        program_words[t][10] = encode_i(opcode_op_imm, 3'b110, 3, 3, 12'd8);
        program_words[t][11] = encode_s(3, 0, 12'h048);
        program_words[t][12] = encode_j(0, 21'd0);
        expected_address[t]  = 32'h0000_0048;
        expected_data[t]     = result;
    endtask

    // **************************************************
    // program table
    // **************************************************
    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            for (int i = 0; i < 16; i++) begin
                program_words[t][i] = fill_word(i);
            end
            hold_halt[t] = 1'b0;
        end
        // register forms of sra, sub and sltu
        program_words[0][0] = encode_u(opcode_lui, 1, 20'h80000);
        program_words[0][1] = encode_i(opcode_op_imm, 3'b000, 2, 0, 12'd4);
        program_words[0][2] = encode_r(7'b0100000, 3'b101, 3, 1, 2);
        program_words[0][3] = encode_i(opcode_op_imm, 3'b000, 4, 0, 12'h123);
        program_words[0][4] = encode_r(7'b0100000, 3'b000, 5, 3, 4);
        program_words[0][5] = encode_r(7'b0000000, 3'b011, 6, 4, 3);
        program_words[0][6] = encode_r(7'b0000000, 3'b000, 7, 5, 6);
        program_words[0][7] = encode_s(7, 0, 12'h040);
        program_words[0][8] = encode_j(0, 21'd0);
        expected_address[0] = 32'h0000_0040;
        expected_data[0]    = 32'hf7ff_fede;
        // immediate forms where srai needs funct7 bit 5
        program_words[1][0]  = encode_i(opcode_op_imm, 3'b000, 1, 0, -12'd16);
        program_words[1][1]  = encode_i(opcode_op_imm, 3'b101, 2, 1, 12'd4);
        program_words[1][2]  = encode_i(opcode_op_imm, 3'b101, 3, 1, 12'h402);
        program_words[1][3]  = encode_i(opcode_op_imm, 3'b100, 4, 2, 12'h0f0);
        program_words[1][4]  = encode_i(opcode_op_imm, 3'b010, 5, 1, 12'd0);
        program_words[1][5]  = encode_i(opcode_op_imm, 3'b001, 6, 5, 12'd8);
        program_words[1][6]  = encode_r(7'b0000000, 3'b100, 7, 4, 6);
        program_words[1][7]  = encode_r(7'b0000000, 3'b111, 8, 7, 3);
        program_words[1][8]  = encode_i(opcode_op_imm, 3'b011, 9, 2, 12'hfff);
        program_words[1][9]  = encode_r(7'b0000000, 3'b000, 10, 8, 9);
        program_words[1][10] = encode_s(10, 0, 12'h044);
        program_words[1][11] = encode_j(0, 21'd0);
        expected_address[1]  = 32'h0000_0044;
        expected_data[1]     = 32'h0fff_fe0d;
        // load a data word, add to it and store it
        program_words[2][0]  = encode_i(opcode_load, 3'b010, 1, 0, 12'h030);
        program_words[2][1]  = encode_i(opcode_op_imm, 3'b000, 2, 0, 12'h060);
        program_words[2][2]  = encode_i(opcode_op_imm, 3'b000, 3, 1, 12'h025);
        program_words[2][3]  = encode_s(3, 2, 12'h008);
        program_words[2][4]  = encode_j(0, 21'd0);
        program_words[2][12] = 32'h1234_5678;
        expected_address[2]  = 32'h0000_0068;
        expected_data[2]     = 32'h1234_569d;
        build_branch_program(3, -12'd5, 12'd3, 32'h0000_0009);
        build_branch_program(4, 12'd3, 12'd3, 32'h0000_0006);
        build_branch_program(5, 12'd7, -12'd2, 32'h0000_0005);
        // sum of lui, auipc and both link values
        program_words[6][0]  = encode_u(opcode_lui, 1, 20'h12345);
        program_words[6][1]  = encode_u(opcode_auipc, 2, 20'h00001);
        program_words[6][2]  = encode_j(3, 21'd8);
        program_words[6][3]  = encode_i(opcode_op_imm, 3'b000, 1, 0, 12'd0);
        program_words[6][4]  = encode_i(opcode_op_imm, 3'b000, 5, 0, 12'h01c);
        program_words[6][5]  = encode_i(opcode_jalr, 3'b000, 4, 5, 12'd0);
        program_words[6][6]  = encode_i(opcode_op_imm, 3'b000, 1, 0, 12'd0);
        program_words[6][7]  = encode_r(7'b0000000, 3'b000, 6, 1, 2);
        program_words[6][8]  = encode_r(7'b0000000, 3'b000, 6, 6, 3);
        program_words[6][9]  = encode_r(7'b0000000, 3'b000, 6, 6, 4);
        program_words[6][10] = encode_s(6, 0, 12'h04c);
        program_words[6][11] = encode_j(0, 21'd0);
        expected_address[6]  = 32'h0000_004c;
        expected_data[6]     = 32'h1234_6028;
        program_words[7][0] = encode_i(opcode_op_imm, 3'b000, 1, 0, 12'h05a);
        program_words[7][1] = encode_i(opcode_op_imm, 3'b000, 1, 1, 12'h100);
        program_words[7][2] = encode_s(1, 0, 12'h050);
        program_words[7][3] = encode_j(0, 21'd0);
        expected_address[7] = 32'h0000_0050;
        expected_data[7]    = 32'h0000_015a;
        hold_halt[7]        = 1'b1;
    endtask

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string signal_name, input word_t actual,
                              input word_t expected);
        if (actual !== expected) begin
            $display("mismatch %s in program %0d: got %h, expected %h",
                     signal_name, current_test, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string signal_name, input logic actual,
                              input logic expected);
        if (actual !== expected) begin
            $display("mismatch %s in program %0d: got %h, expected %h",
                     signal_name, current_test, actual, expected);
            abort_run();
        end
    endtask

    task automatic load_memory(input int t);
        for (int i = 0; i < memory_words; i++) begin
            if (i < 16) begin
                memory[i] = program_words[t][i];
            end else begin
                memory[i] = fill_word(i);
            end
        end
    endtask

    task automatic run_program(input int t);
        int cycles;
        current_test = t;
        @(posedge clk);
        #5;
        reset = 1'b1;
        halt  = hold_halt[t];
        repeat (15) begin
            @(posedge clk);
            #50;
            check_flag("memory_read", memory_read, 1'b0);
            check_flag("memory_write", memory_write, 1'b0);
        end
        load_memory(t);
        @(posedge clk);
        #5;
        reset = 1'b0;
        if (hold_halt[t]) begin
            repeat (20) begin
                @(posedge clk);
                #50;
                check_flag("memory_read", memory_read, 1'b0);
            end
            @(posedge clk);
            #5;
            halt = 1'b0;
        end
        // first fetch one cycle after the core may start
        @(posedge clk);
        #50;
        check_flag("memory_read", memory_read, 1'b1);
        check_word("address", address, boot_address);
        cycles = 0;
        while (memory_write !== 1'b1) begin
            if (cycles == cycles_per_program) begin
                $display("no store seen within %0d cycles in program %0d", cycles, t);
                abort_run();
            end
            @(posedge clk);
            #50;
            cycles++;
        end
        check_word("address", address, expected_address[t]);
        check_word("write_data", write_data, expected_data[t]);
    endtask

    // **************************************************
    // memory model answering after 1 to 4 cycles
    // **************************************************
    initial begin : memory_model
        logic busy;
        int   wait_cycles;
        busy        = 1'b0;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            #5;
            if (memory_response || reset) begin
                memory_response = 1'b0;
                busy            = 1'b0;
            end
            if (busy) begin
                wait_cycles = wait_cycles - 1;
                if (wait_cycles == 0) begin
                    if (memory_write) begin
                        memory[address[7:2]] = write_data;
                    end else begin
                        read_data = memory[address[7:2]];
                    end
                    memory_response = 1'b1;
                end
            end else if (!reset && (memory_read || memory_write)) begin
                busy        = 1'b1;
                wait_cycles = 1 + ($random(seed) & 3);
            end
        end
    end

    initial begin : watchdog
        #(num_tests * cycles_per_program * clock_period);
        $display("timeout: the programs did not finish in time");
        abort_run();
    end

    initial begin
        reset           = 1'b1;
        halt            = 1'b0;
        memory_response = 1'b0;
        read_data       = '0;
        current_test    = 0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_program(t);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/core.sv ====
`timescale 1ns/1ns
`default_nettype none

module core #(
    parameter core_pkg::word_t boot_address = 32'h0000_0000
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   halt,
    input  wire                   memory_response,
    input  wire core_pkg::word_t  read_data,
    output wire                   memory_read,
    output wire                   memory_write,
    output core_pkg::word_t       address,
    output core_pkg::word_t       write_data
);
    import core_pkg::*;

    // control unit outputs
    logic       pc_write;
    logic       pc_write_cond;
    logic       ir_write;
    logic       address_from_alu;
    logic       reg_write;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    wb_sel_t    wb_sel;
    logic       alu_force_op;
    alu_op_t    alu_forced_op;
    logic       alu_decode_immediate;

    // datapath registers
    word_t pc_q;
    word_t old_pc_q;
    word_t instruction_q;
    word_t mdr_q;
    word_t rs1_q;
    word_t rs2_q;
    word_t alu_result_q;

    word_t read_data_1;
    word_t read_data_2;
    word_t immediate;
    word_t operand_a;
    word_t operand_b;
    word_t alu_result;
    word_t writeback_data;
    word_t pc_next;
    logic  zero;

    // **************************************************
    // program counter
    // **************************************************
    // a taken branch uses the target computed in decode
    assign pc_next = pc_write_cond ? alu_result_q : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= boot_address;
        end else if (pc_write || pc_write_cond) begin
            pc_q <= {pc_next[31:1], 1'b0};
        end
    end

    // instruction, memory data and operand registers
    always_ff @(posedge clk) begin
        if (ir_write) begin
            instruction_q <= read_data;
            old_pc_q      <= pc_q;
        end
        if (memory_response) begin
            mdr_q <= read_data;
        end
        rs1_q        <= read_data_1;
        rs2_q        <= read_data_2;
        alu_result_q <= alu_result;
    end

    // **************************************************
    // operand and writeback muxes
    // **************************************************
    always_comb begin
        case (alu_a_sel)
            a_sel_pc:     operand_a = pc_q;
            a_sel_old_pc: operand_a = old_pc_q;
            a_sel_rs1:    operand_a = rs1_q;
            default:      operand_a = '0;
        endcase
    end

    always_comb begin
        case (alu_b_sel)
            b_sel_rs2:  operand_b = rs2_q;
            b_sel_four: operand_b = 32'd4;
            default:    operand_b = immediate;
        endcase
    end

    always_comb begin
        case (wb_sel)
            wb_sel_mdr: writeback_data = mdr_q;
            wb_sel_pc:  writeback_data = pc_q;
            default:    writeback_data = alu_result_q;
        endcase
    end

    assign address    = address_from_alu ? alu_result_q : pc_q;
    assign write_data = rs2_q;

    control_unit control_unit_i (
        .clk                  (clk),
        .reset                (reset),
        .halt                 (halt),
        .memory_response      (memory_response),
        .opcode               (instruction_q[6:0]),
        .funct3               (instruction_q[14:12]),
        .zero                 (zero),
        .pc_write             (pc_write),
        .pc_write_cond        (pc_write_cond),
        .branch_invert        (),
        .ir_write             (ir_write),
        .address_from_alu     (address_from_alu),
        .memory_read          (memory_read),
        .memory_write         (memory_write),
        .reg_write            (reg_write),
        .alu_a_sel            (alu_a_sel),
        .alu_b_sel            (alu_b_sel),
        .wb_sel               (wb_sel),
        .alu_force_op         (alu_force_op),
        .alu_forced_op        (alu_forced_op),
        .alu_decode_immediate (alu_decode_immediate)
    );

    register_file register_file_i (
        .clk          (clk),
        .reg_write    (reg_write),
        .read_index_1 (instruction_q[19:15]),
        .read_index_2 (instruction_q[24:20]),
        .write_index  (instruction_q[11:7]),
        .write_data   (writeback_data),
        .read_data_1  (read_data_1),
        .read_data_2  (read_data_2)
    );

    alu alu_i (
        .force_op         (alu_force_op),
        .forced_op        (alu_forced_op),
        .decode_immediate (alu_decode_immediate),
        .funct3           (instruction_q[14:12]),
        .funct7_bit5      (instruction_q[30]),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .result           (alu_result),
        .zero             (zero)
    );

    immediate_generator immediate_generator_i (
        .instruction (instruction_q),
        .immediate   (immediate)
    );

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     halt,
    input  wire                     memory_response,
    input  wire core_pkg::opcode_t  opcode,
    input  wire [2:0]               funct3,
    input  wire                     zero,
    output logic                    pc_write,
    output logic                    pc_write_cond,
    output logic                    branch_invert,
    output logic                    ir_write,
    output logic                    address_from_alu,
    output logic                    memory_read,
    output logic                    memory_write,
    output logic                    reg_write,
    output core_pkg::alu_a_sel_t    alu_a_sel,
    output core_pkg::alu_b_sel_t    alu_b_sel,
    output core_pkg::wb_sel_t       wb_sel,
    output logic                    alu_force_op,
    output core_pkg::alu_op_t       alu_forced_op,
    output logic                    alu_decode_immediate
);
    import core_pkg::*;

    typedef enum logic [2:0] {
        state_idle,
        state_fetch,
        state_decode,
        state_execute,
        state_memory,
        state_writeback
    } state_t;

    state_t  state_q;
    state_t  state_d;
    state_t  fetch_or_idle;
    alu_op_t branch_op;
    logic    branch_taken;
    logic    is_load;

    // halt is sampled at each instruction boundary
    assign fetch_or_idle = halt ? state_idle : state_fetch;
    assign is_load       = (opcode == opcode_load);

    // **************************************************
    // branch compare selection
    // **************************************************
    always_comb begin
        if (funct3[2]) begin
            // blt/bge compare with slt, zero means rs1 >= rs2
            branch_op     = funct3[1] ? alu_sltu : alu_slt;
            branch_invert = ~funct3[0];
        end else begin
            branch_op     = alu_sub;
            branch_invert = funct3[0];
        end
    end

    assign branch_taken = zero ^ branch_invert;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // **************************************************
    // next state and datapath controls
    // **************************************************
    always_comb begin
        state_d              = state_q;
        pc_write             = 1'b0;
        pc_write_cond        = 1'b0;
        ir_write             = 1'b0;
        address_from_alu     = 1'b0;
        memory_read          = 1'b0;
        memory_write         = 1'b0;
        reg_write            = 1'b0;
        alu_a_sel            = a_sel_pc;
        alu_b_sel            = b_sel_four;
        wb_sel               = wb_sel_alu;
        alu_force_op         = 1'b1;
        alu_forced_op        = alu_add;
        alu_decode_immediate = 1'b0;

        case (state_q)
            state_idle: begin
                state_d = fetch_or_idle;
            end
            state_fetch: begin
                // pc + 4 goes to the pc with the instruction
                memory_read = 1'b1;
                if (memory_response) begin
                    ir_write = 1'b1;
                    pc_write = 1'b1;
                    state_d  = state_decode;
                end
            end
            state_decode: begin
                // branch target lands in the alu result register
                alu_a_sel = a_sel_old_pc;
                alu_b_sel = b_sel_imm;
                state_d   = state_execute;
            end
            state_execute: begin
                case (opcode)
                    opcode_op: begin
                        alu_a_sel    = a_sel_rs1;
                        alu_b_sel    = b_sel_rs2;
                        alu_force_op = 1'b0;
                        state_d      = state_writeback;
                    end
                    opcode_op_imm: begin
                        alu_a_sel            = a_sel_rs1;
                        alu_b_sel            = b_sel_imm;
                        alu_force_op         = 1'b0;
                        alu_decode_immediate = 1'b1;
                        state_d              = state_writeback;
                    end
                    opcode_lui: begin
                        alu_a_sel = a_sel_zero;
                        alu_b_sel = b_sel_imm;
                        state_d   = state_writeback;
                    end
                    opcode_auipc: begin
                        alu_a_sel = a_sel_old_pc;
                        alu_b_sel = b_sel_imm;
                        state_d   = state_writeback;
                    end
                    opcode_load, opcode_store: begin
                        alu_a_sel = a_sel_rs1;
                        alu_b_sel = b_sel_imm;
                        state_d   = state_memory;
                    end
                    opcode_branch: begin
                        alu_a_sel     = a_sel_rs1;
                        alu_b_sel     = b_sel_rs2;
                        alu_forced_op = branch_op;
                        pc_write_cond = branch_taken;
                        state_d       = fetch_or_idle;
                    end
                    opcode_jal, opcode_jalr: begin
                        // link is the pc, which already holds pc + 4
                        alu_a_sel = (opcode == opcode_jal) ? a_sel_old_pc : a_sel_rs1;
                        alu_b_sel = b_sel_imm;
                        pc_write  = 1'b1;
                        reg_write = 1'b1;
                        wb_sel    = wb_sel_pc;
                        state_d   = fetch_or_idle;
                    end
                    default: state_d = fetch_or_idle;
                endcase
            end
            state_memory: begin
                // same alu inputs keep the address steady
                alu_a_sel        = a_sel_rs1;
                alu_b_sel        = b_sel_imm;
                address_from_alu = 1'b1;
                memory_read      = is_load;
                memory_write     = ~is_load;
                if (memory_response) begin
                    state_d = is_load ? state_writeback : fetch_or_idle;
                end
            end
            state_writeback: begin
                reg_write = 1'b1;
                wb_sel    = is_load ? wb_sel_mdr : wb_sel_alu;
                state_d   = fetch_or_idle;
            end
            default: state_d = state_idle;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/immediate_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module immediate_generator (
    input  wire core_pkg::word_t  instruction,
    output core_pkg::word_t       immediate
);
    import core_pkg::*;

    opcode_t opcode;

    assign opcode = instruction[6:0];

    always_comb begin
        case (opcode)
            // i-type
            opcode_op_imm, opcode_load, opcode_jalr: begin
                immediate = {{20{instruction[31]}}, instruction[31:20]};
            end
            opcode_store: begin
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            opcode_branch: begin
                immediate = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            end
            opcode_jal: begin
                immediate = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            end
            // u-type, low bits are zero
            opcode_lui, opcode_auipc: begin
                immediate = {instruction[31:12], 12'b0};
            end
            default: immediate = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                        clk,
    input  wire                        reg_write,
    input  wire core_pkg::reg_index_t  read_index_1,
    input  wire core_pkg::reg_index_t  read_index_2,
    input  wire core_pkg::reg_index_t  write_index,
    input  wire core_pkg::word_t       write_data,
    output core_pkg::word_t            read_data_1,
    output core_pkg::word_t            read_data_2
);
    import core_pkg::*;

    // x0 has no storage
    word_t registers [1:31];

    always_ff @(posedge clk) begin
        if (reg_write && write_index != '0) begin
            registers[write_index] <= write_data;
        end
    end

    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire                     force_op,
    input  wire core_pkg::alu_op_t  forced_op,
    input  wire                     decode_immediate,
    input  wire [2:0]               funct3,
    input  wire                     funct7_bit5,
    input  wire core_pkg::word_t    operand_a,
    input  wire core_pkg::word_t    operand_b,
    output core_pkg::word_t         result,
    output logic                    zero
);
    import core_pkg::*;

    alu_op_t decoded_op;
    alu_op_t op;

    // funct3/funct7 decode for op and op-imm instructions
    always_comb begin
        case (funct3)
            3'b000:  decoded_op = (!decode_immediate && funct7_bit5) ? alu_sub : alu_add;
            3'b001:  decoded_op = alu_sll;
            3'b010:  decoded_op = alu_slt;
            3'b011:  decoded_op = alu_sltu;
            3'b100:  decoded_op = alu_xor;
            // srai keeps funct7 bit 5 even in the immediate form
            3'b101:  decoded_op = funct7_bit5 ? alu_sra : alu_srl;
            3'b110:  decoded_op = alu_or;
            default: decoded_op = alu_and;
        endcase
    end

    assign op = force_op ? forced_op : decoded_op;

    always_comb begin
        case (op)
            alu_add:  result = operand_a + operand_b;
            alu_sub:  result = operand_a - operand_b;
            alu_and:  result = operand_a & operand_b;
            alu_or:   result = operand_a | operand_b;
            alu_xor:  result = operand_a ^ operand_b;
            alu_slt:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            alu_sltu: result = {31'b0, operand_a < operand_b};
            alu_sll:  result = operand_a << operand_b[4:0];
            alu_srl:  result = operand_a >> operand_b[4:0];
            alu_sra:  result = word_t'($signed(operand_a) >>> operand_b[4:0]);
            default:  result = '0;
        endcase
    end

    // used by the branch compares
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // machine word, used for data, addresses and the pc
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;

    // **************************************************
    // major opcodes of the supported rv32i subset
    // **************************************************
    localparam opcode_t opcode_op     = 7'b0110011;
    localparam opcode_t opcode_op_imm = 7'b0010011;
    localparam opcode_t opcode_load   = 7'b0000011;
    localparam opcode_t opcode_store  = 7'b0100011;
    localparam opcode_t opcode_branch = 7'b1100011;
    localparam opcode_t opcode_jal    = 7'b1101111;
    localparam opcode_t opcode_jalr   = 7'b1100111;
    localparam opcode_t opcode_lui    = 7'b0110111;
    localparam opcode_t opcode_auipc  = 7'b0010111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // operand and writeback source selects
    typedef enum logic [1:0] {a_sel_pc, a_sel_old_pc, a_sel_rs1, a_sel_zero} alu_a_sel_t;

    typedef enum logic [1:0] {b_sel_rs2, b_sel_four, b_sel_imm} alu_b_sel_t;

    typedef enum logic [1:0] {wb_sel_alu, wb_sel_mdr, wb_sel_pc} wb_sel_t;

endpackage

`default_nettype wire
